// File: alu.sv
// integer ALU
// purely combinational, one result per opcode

`timescale 1ns/1ps

module alu (
    input  core_types_pkg::alu_op_e op,
    input  logic [31:0]             A,
    input  logic [31:0]             B,
    output logic [31:0]             out
);
    import core_types_pkg::*;

    logic [4:0] shamt;

    // shifts only look at the low bits of B
    assign shamt = B[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  out = A + B;
            ALU_SUB:  out = A - B;
            ALU_SLL:  out = A << shamt;
            ALU_SLT:  out = {31'b0, $signed(A) < $signed(B)};
            ALU_SLTU: out = {31'b0, A < B};
            ALU_XOR:  out = A ^ B;
            ALU_SRL:  out = A >> shamt;
            ALU_SRA:  out = $unsigned($signed(A) >>> shamt);
            ALU_OR:   out = A | B;
            ALU_AND:  out = A & B;
            // encodings outside the set
            default:  out = 32'h0;
        endcase
    end

endmodule

// File: alu_reg_core.sv
// ALU lane subsystem top
// joins the register-register lane to the banked register file

`timescale 1ns/1ps

module alu_reg_core (
    input  logic CLK,
    input  logic nRST,

    input  core_types_pkg::alu_issue_t issue,
    output logic                       issue_ready,

    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0] bank_busy,
    input  core_types_pkg::prf_write_t [core_types_pkg::PRF_BANK_COUNT-1:0] ext_write,

    output core_types_pkg::alu_wb_t wb,
    input  logic                    WB_ready
);
    import core_types_pkg::*;

    // lane to register file
    logic issue_accept;

    // register file to lane
    logic                                 A_read_ack, A_read_port;
    logic                                 B_read_ack, B_read_port;
    logic [PRF_BANK_COUNT-1:0][1:0][31:0] read_data_by_bank_by_port;
    logic [PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank;

    alu_reg_pipeline u_pipeline (
        .CLK                       (CLK),
        .nRST                      (nRST),
        .issue                     (issue),
        .issue_ready               (issue_ready),
        .issue_accept              (issue_accept),
        .A_read_ack                (A_read_ack),
        .A_read_port               (A_read_port),
        .B_read_ack                (B_read_ack),
        .B_read_port               (B_read_port),
        .read_data_by_bank_by_port (read_data_by_bank_by_port),
        .forward_data_by_bank      (forward_data_by_bank),
        .wb                        (wb),
        .WB_ready                  (WB_ready)
    );

    prf u_prf (
        .CLK                       (CLK),
        .nRST                      (nRST),
        .issue                     (issue),
        .issue_accept              (issue_accept),
        .bank_busy                 (bank_busy),
        .ext_write                 (ext_write),
        .wb                        (wb),
        .WB_ready                  (WB_ready),
        .A_read_ack                (A_read_ack),
        .A_read_port               (A_read_port),
        .B_read_ack                (B_read_ack),
        .B_read_port               (B_read_port),
        .read_data_by_bank_by_port (read_data_by_bank_by_port),
        .forward_data_by_bank      (forward_data_by_bank)
    );

endmodule

// File: alu_reg_core_tb.sv
// testbench for the ALU lane subsystem
// loads source registers, issues instructions from the data file under
// bank contention and writeback back-pressure, checks every writeback

`timescale 1ns/1ps

module alu_reg_core_tb;
    import core_types_pkg::*;

    localparam int         WAIT_LIMIT = 200;
    localparam int         IDLE_SPAN  = 8;
    localparam logic [2:0] BUSY_SPAN  = 3'd3;
    // source modes in the data file
    localparam logic [1:0] MODE_REG   = 2'd0;
    localparam logic [1:0] MODE_FWD   = 2'd1;
    localparam logic [1:0] MODE_ZERO  = 2'd2;
    localparam logic [1:0] MODE_PRIOR = 2'd3;

    typedef struct packed {
        logic [3:0]  op;
        logic [1:0]  a_mode;
        logic [31:0] a_val;
        logic [1:0]  b_mode;
        logic [31:0] b_val;
        logic [4:0]  a_pr;
        logic [4:0]  b_pr;
        logic [4:0]  dest_pr;
        logic [1:0]  busy;
        logic [7:0]  stall;
    } test_line_t;

    logic                                 CLK;
    logic                                 nRST;
    alu_issue_t                           issue;
    logic                                 issue_ready;
    logic [PRF_BANK_COUNT-1:0]            bank_busy;
    prf_write_t [PRF_BANK_COUNT-1:0]      ext_write;
    alu_wb_t                              wb;
    logic                                 WB_ready;

    integer      seed;
    test_line_t  lines[$];
    alu_wb_t     exp_q[$];
    logic [31:0] model_regs [PR_COUNT];
    logic        accepted;
    logic [7:0]  stall_left;
    logic [2:0]  busy_left;
    logic [1:0]  busy_mask;

    alu_reg_core u_alu_reg_core (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue       (issue),
        .issue_ready (issue_ready),
        .bank_busy   (bank_busy),
        .ext_write   (ext_write),
        .wb          (wb),
        .WB_ready    (WB_ready)
    );

    always #4 CLK = ~CLK;

    // ------------------------------------------------------------
    // reference model and reporting

    function automatic logic [31:0] expected_result(input alu_op_e op, input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            // logical shift with the vacated top bits filled from the sign
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] operand_value(input logic [1:0] mode, input logic [31:0] val,
                                                  input logic [4:0] pr);
        if (mode == MODE_ZERO) begin
            return 32'h0;
        end
        if (mode == MODE_FWD) begin
            return val;
        end
        return model_regs[pr];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // ------------------------------------------------------------
    // per-cycle driving and monitoring

    task automatic take_writeback();
        alu_wb_t want;
        if (exp_q.size() == 0) begin
            abort_run("a writeback completed with no instruction outstanding");
        end else begin
            want = exp_q.pop_front();
            check_value("wb.data", wb.data, want.data);
            check_value("wb.dest_pr", 32'(wb.dest_pr), 32'(want.dest_pr));
            check_value("wb.rob_index", 32'(wb.rob_index), 32'(want.rob_index));
            model_regs[want.dest_pr] = want.data;
        end
    endtask

    // samples at the falling edge and drives 1 ns after the rising edge
    task automatic tick();
        logic [31:0] rnd;
        @(negedge CLK);
        accepted = issue.valid && issue_ready;
        if (wb.valid && WB_ready) begin
            take_writeback();
        end
        @(posedge CLK);
        #1;
        ext_write = '0;
        if (stall_left != 8'd0) begin
            WB_ready   = 1'b0;
            stall_left = stall_left - 8'd1;
        end else begin
            rnd      = $random(seed);
            WB_ready = rnd[1:0] != 2'b00;
        end
        if (busy_left != 3'd0) begin
            bank_busy = busy_mask;
            busy_left = busy_left - 3'd1;
        end else begin
            bank_busy = '0;
        end
    endtask

    task automatic drive_write(input logic [4:0] pr, input logic [31:0] val);
        ext_write[pr[0]] = '{valid: 1'b1, pr: pr, data: val};
        model_regs[pr] = val;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("timeout waiting for outstanding writebacks");
            end else begin
                waited++;
                tick();
            end
        end
    endtask

    // ------------------------------------------------------------
    // test sequence

    task automatic load_lines();
        int          fd;
        int          rc;
        string       header;
        logic [31:0] f_op, f_am, f_av, f_bm, f_bv;
        logic [31:0] f_apr, f_bpr, f_dst, f_busy, f_stall;
        fd = $fopen("alu_reg_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open alu_reg_testdata.txt");
        end else begin
            // column description lines
            rc = $fgets(header, fd);
            rc = $fgets(header, fd);
            rc = $fscanf(fd, "%h %d %h %d %h %d %d %d %d %d\n", f_op, f_am, f_av, f_bm, f_bv,
                         f_apr, f_bpr, f_dst, f_busy, f_stall);
            while (rc == 10) begin
                lines.push_back('{op: f_op[3:0], a_mode: f_am[1:0], a_val: f_av,
                                  b_mode: f_bm[1:0], b_val: f_bv, a_pr: f_apr[4:0],
                                  b_pr: f_bpr[4:0], dest_pr: f_dst[4:0], busy: f_busy[1:0],
                                  stall: f_stall[7:0]});
                rc = $fscanf(fd, "%h %d %h %d %h %d %d %d %d %d\n", f_op, f_am, f_av, f_bm, f_bv,
                             f_apr, f_bpr, f_dst, f_busy, f_stall);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input int idx);
        test_line_t ln;
        logic [31:0] a_op;
        logic [31:0] b_op;
        int          waited;
        ln = lines[idx];
        // a source naming an earlier destination is read after that writeback
        if (ln.a_mode == MODE_PRIOR || ln.b_mode == MODE_PRIOR) begin
            drain();
        end
        a_op = operand_value(ln.a_mode, ln.a_val, ln.a_pr);
        b_op = operand_value(ln.b_mode, ln.b_val, ln.b_pr);
        exp_q.push_back('{valid: 1'b1, data: expected_result(alu_op_e'(ln.op), a_op, b_op),
                          dest_pr: ln.dest_pr, rob_index: LOG_ROB_ENTRIES'(idx)});
        issue = '{valid: 1'b1, op: alu_op_e'(ln.op),
                  a_forward: ln.a_mode == MODE_FWD, a_is_zero: ln.a_mode == MODE_ZERO,
                  a_pr: ln.a_pr,
                  b_forward: ln.b_mode == MODE_FWD, b_is_zero: ln.b_mode == MODE_ZERO,
                  b_pr: ln.b_pr, dest_pr: ln.dest_pr, rob_index: LOG_ROB_ENTRIES'(idx)};
        waited = 0;
        tick();
        while (!accepted) begin
            if (waited >= WAIT_LIMIT) begin
                abort_run("timeout waiting for the lane to accept an instruction");
            end else begin
                waited++;
                tick();
            end
        end
        // first collect cycle
        issue      = '0;
        stall_left = ln.stall;
        busy_mask  = ln.busy;
        busy_left  = BUSY_SPAN;
        bank_busy  = ln.busy;
        if (ln.a_mode == MODE_FWD) begin
            drive_write(ln.a_pr, ln.a_val);
        end
        if (ln.b_mode == MODE_FWD) begin
            drive_write(ln.b_pr, ln.b_val);
        end
    endtask

    initial begin
        seed       = 76854;
        CLK        = 1'b0;
        nRST       = 1'b0;
        issue      = '0;
        bank_busy  = '0;
        ext_write  = '0;
        WB_ready   = 1'b0;
        accepted   = 1'b0;
        stall_left = 8'd0;
        busy_left  = 3'd0;
        busy_mask  = 2'b00;
        load_lines();

        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        check_value("wb.valid", 32'(wb.valid), 32'd0);
        check_value("issue_ready", 32'(issue_ready), 32'd1);
        @(posedge CLK);
        #1;

        // register sources go in first at one write per cycle
        foreach (lines[i]) begin
            if (lines[i].a_mode == MODE_REG) begin
                drive_write(lines[i].a_pr, lines[i].a_val);
                tick();
            end
            if (lines[i].b_mode == MODE_REG) begin
                drive_write(lines[i].b_pr, lines[i].b_val);
                tick();
            end
        end
        tick();

        foreach (lines[i]) begin
            run_line(i);
        end
        drain();

        // with the queue empty any further writeback is a duplicate
        repeat (IDLE_SPAN) begin
            tick();
        end

        if (lines.size() != 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("no instructions were read from alu_reg_testdata.txt");
            $display("Simulation failed");
            $fatal(1, "empty data file");
        end
    end

endmodule

// File: alu_reg_pipeline.sv
// register-register ALU lane
// operand collect stage, then a writeback register feeding the ALU
// holds partial operands across stalls so acks are never repeated

`timescale 1ns/1ps

module alu_reg_pipeline (
    input  logic CLK,
    input  logic nRST,

    // issue
    input  core_types_pkg::alu_issue_t issue,
    output logic                       issue_ready,
    output logic                       issue_accept,

    // register file read grants and data
    input  logic A_read_ack,
    input  logic A_read_port,
    input  logic B_read_ack,
    input  logic B_read_port,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] read_data_by_bank_by_port,
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank,

    // writeback
    output core_types_pkg::alu_wb_t wb,
    input  logic                    WB_ready
);
    import core_types_pkg::*;

    // operand priority: zero, saved, forward, register read
    function automatic logic [31:0] pick_operand(
        input logic        is_zero,
        input logic        saved,
        input logic [31:0] saved_data,
        input logic        forward,
        input logic [31:0] fwd_data,
        input logic [31:0] read_data
    );
        if (is_zero) begin
            return 32'h0;
        end
        if (saved) begin
            return saved_data;
        end
        if (forward) begin
            return fwd_data;
        end
        return read_data;
    endfunction

    // ------------------------------------------------------------
    // collect stage state

    logic                          valid_oc;
    alu_op_e                       op_oc;
    logic                          a_saved, a_forward, a_is_zero;
    logic                          b_saved, b_forward, b_is_zero;
    logic [LOG_PRF_BANK_COUNT-1:0] a_bank, b_bank;
    logic [LOG_PR_COUNT-1:0]       dest_pr_oc;
    logic [LOG_ROB_ENTRIES-1:0]    rob_index_oc;
    logic [31:0]                   a_saved_data, b_saved_data;
    logic [31:0]                   next_a, next_b;
    logic                          a_present, b_present;
    logic                          launch;

    // writeback stage state
    logic                       wb_valid;
    alu_op_e                    wb_op;
    logic [31:0]                wb_a, wb_b;
    logic [31:0]                wb_data;
    logic [LOG_PR_COUNT-1:0]    wb_pr;
    logic [LOG_ROB_ENTRIES-1:0] wb_rob_index;
    logic                       stall_wb;

    // ------------------------------------------------------------
    // stall and launch control

    assign stall_wb = wb_valid & ~WB_ready;

    assign a_present = a_is_zero | a_saved | a_forward | A_read_ack;
    assign b_present = b_is_zero | b_saved | b_forward | B_read_ack;

    assign launch = valid_oc & a_present & b_present & ~stall_wb;

    assign issue_ready  = ~valid_oc | launch;
    assign issue_accept = issue.valid & issue_ready;

    assign next_a = pick_operand(a_is_zero, a_saved, a_saved_data, a_forward,
        forward_data_by_bank[a_bank], read_data_by_bank_by_port[a_bank][A_read_port]);
    assign next_b = pick_operand(b_is_zero, b_saved, b_saved_data, b_forward,
        forward_data_by_bank[b_bank], read_data_by_bank_by_port[b_bank][B_read_port]);

    // ------------------------------------------------------------
    // collect stage

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_oc  <= 1'b0;
            a_saved   <= 1'b0;
            a_forward <= 1'b0;
            a_is_zero <= 1'b0;
            b_saved   <= 1'b0;
            b_forward <= 1'b0;
            b_is_zero <= 1'b0;
        end else if (!issue_ready) begin
            // holding, remember whatever arrived this cycle
            a_saved   <= a_saved | a_forward | A_read_ack;
            a_forward <= 1'b0;
            b_saved   <= b_saved | b_forward | B_read_ack;
            b_forward <= 1'b0;
        end else begin
            valid_oc  <= issue.valid;
            a_saved   <= 1'b0;
            a_forward <= issue.a_forward;
            a_is_zero <= issue.a_is_zero;
            b_saved   <= 1'b0;
            b_forward <= issue.b_forward;
            b_is_zero <= issue.b_is_zero;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            op_oc        <= issue.op;
            a_bank       <= issue.a_pr[LOG_PRF_BANK_COUNT-1:0];
            b_bank       <= issue.b_pr[LOG_PRF_BANK_COUNT-1:0];
            dest_pr_oc   <= issue.dest_pr;
            rob_index_oc <= issue.rob_index;
        end else begin
            a_saved_data <= next_a;
            b_saved_data <= next_b;
        end
    end

    // ------------------------------------------------------------
    // writeback stage

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_valid <= 1'b0;
        end else if (!stall_wb) begin
            wb_valid <= launch;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall_wb) begin
            wb_op        <= op_oc;
            wb_a         <= next_a;
            wb_b         <= next_b;
            wb_pr        <= dest_pr_oc;
            wb_rob_index <= rob_index_oc;
        end
    end

    alu u_alu (
        .op  (wb_op),
        .A   (wb_a),
        .B   (wb_b),
        .out (wb_data)
    );

    assign wb = '{valid: wb_valid, data: wb_data, dest_pr: wb_pr, rob_index: wb_rob_index};

endmodule

// File: alu_reg_testdata.txt
# op(hex) a_mode a_val(hex) b_mode b_val(hex) a_pr b_pr dest_pr busy_mask wb_stall_cycles
# modes: 0 register, 1 forward, 2 zero, 3 earlier result (value column ignored)
0 0 00000005 0 00000007 1 2 20 0 0
8 0 00000010 0 00000020 3 4 21 0 0
1 0 80000001 0 00000024 5 6 22 0 0
2 0 fffffff0 0 00000003 7 8 23 0 0
3 0 fffffff0 0 00000003 9 10 24 1 3
4 0 a5a5a5a5 0 0f0f0f0f 11 12 25 3 0
5 0 f0000000 0 00000004 13 14 26 0 6
d 0 f0000000 0 00000008 15 16 27 2 0
6 0 12340000 0 00005678 17 18 28 0 0
7 0 ff00ff00 0 a5a5a5a5 19 11 29 0 10
8 2 00000000 0 00000020 0 4 30 1 0
6 1 00000100 2 00000000 0 0 31 0 2
0 1 0000003c 1 0000003c 0 0 20 0 0
2 0 fffffff0 1 7fffffff 7 19 21 2 0
8 3 00000000 0 00000010 20 3 23 0 0
4 3 00000000 3 00000000 31 30 24 0 5

// File: core_types_pkg.sv
// shared sizes, ALU opcodes and bundle types for the
// register-register ALU lane and the banked register file

package core_types_pkg;

    // ------------------------------------------------------------
    // sizes

    localparam int PR_COUNT = 32;
    localparam int LOG_PR_COUNT = 5;

    localparam int PRF_BANK_COUNT = 2;
    localparam int LOG_PRF_BANK_COUNT = 1;

    // rows in each bank, indexed by the upper register bits
    localparam int PRF_ROW_COUNT = PR_COUNT / PRF_BANK_COUNT;
    localparam int LOG_PRF_ROW_COUNT = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;

    localparam int ROB_ENTRIES = 16;
    localparam int LOG_ROB_ENTRIES = 4;

    // ------------------------------------------------------------
    // opcodes, {funct7[5], funct3}

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    // ------------------------------------------------------------
    // bundles

    typedef struct packed {
        logic                       valid;
        alu_op_e                    op;
        logic                       a_forward;
        logic                       a_is_zero;
        logic [LOG_PR_COUNT-1:0]    a_pr;
        logic                       b_forward;
        logic                       b_is_zero;
        logic [LOG_PR_COUNT-1:0]    b_pr;
        logic [LOG_PR_COUNT-1:0]    dest_pr;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
    } alu_issue_t;

    typedef struct packed {
        logic                       valid;
        logic [31:0]                data;
        logic [LOG_PR_COUNT-1:0]    dest_pr;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
    } alu_wb_t;

    typedef struct packed {
        logic                    valid;
        logic [LOG_PR_COUNT-1:0] pr;
        logic [31:0]             data;
    } prf_write_t;

endpackage

// File: prf.sv
// banked physical register file model
// tracks the lane's read requests, grants ports per bank, and takes
// one outside write plus the lane writeback each cycle

`timescale 1ns/1ps

module prf (
    input  logic CLK,
    input  logic nRST,

    // accepted issue from the lane
    input  core_types_pkg::alu_issue_t issue,
    input  logic                       issue_accept,

    // other lanes hold the read ports of a busy bank
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0] bank_busy,

    // writes
    input  core_types_pkg::prf_write_t [core_types_pkg::PRF_BANK_COUNT-1:0] ext_write,
    input  core_types_pkg::alu_wb_t                                         wb,
    input  logic                                                            WB_ready,

    // read grants and data
    output logic A_read_ack,
    output logic A_read_port,
    output logic B_read_ack,
    output logic B_read_port,
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][31:0] read_data_by_bank_by_port,
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0][31:0]      forward_data_by_bank
);
    import core_types_pkg::*;

    logic [31:0] regs [PRF_BANK_COUNT][PRF_ROW_COUNT];

    logic                          a_pending, b_pending;
    logic [LOG_PR_COUNT-1:0]       a_pr, b_pr;
    logic [LOG_PRF_BANK_COUNT-1:0] a_bank, b_bank;
    logic [LOG_PRF_ROW_COUNT-1:0]  a_row, b_row;

    assign a_bank = a_pr[LOG_PRF_BANK_COUNT-1:0];
    assign b_bank = b_pr[LOG_PRF_BANK_COUNT-1:0];
    assign a_row  = a_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
    assign b_row  = b_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];

    // ------------------------------------------------------------
    // pending reads

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            a_pending <= 1'b0;
            b_pending <= 1'b0;
        end else if (issue_accept) begin
            a_pending <= ~issue.a_forward & ~issue.a_is_zero;
            b_pending <= ~issue.b_forward & ~issue.b_is_zero;
        end else begin
            if (A_read_ack) begin
                a_pending <= 1'b0;
            end
            if (B_read_ack) begin
                b_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_accept) begin
            a_pr <= issue.a_pr;
            b_pr <= issue.b_pr;
        end
    end

    // A always takes port 0, B moves to port 1 when sharing a bank
    assign A_read_ack  = a_pending & ~bank_busy[a_bank];
    assign B_read_ack  = b_pending & ~bank_busy[b_bank];
    assign A_read_port = 1'b0;
    assign B_read_port = A_read_ack & B_read_ack & (a_bank == b_bank);

    // ------------------------------------------------------------
    // read ports and forward data

    for (genvar k = 0; k < PRF_BANK_COUNT; k++) begin : g_bank
        logic [LOG_PRF_ROW_COUNT-1:0] port0_row;

        assign port0_row = (A_read_ack && a_bank == LOG_PRF_BANK_COUNT'(k)) ? a_row : b_row;
        assign read_data_by_bank_by_port[k][0] = regs[k][port0_row];
        assign read_data_by_bank_by_port[k][1] = regs[k][b_row];
        assign forward_data_by_bank[k] = ext_write[k].data;
    end

    // ------------------------------------------------------------
    // writes, outside write lands last so it wins a collision

    always_ff @(posedge CLK) begin
        if (wb.valid && WB_ready) begin
            regs[wb.dest_pr[LOG_PRF_BANK_COUNT-1:0]]
                [wb.dest_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]] <= wb.data;
        end
        for (int k = 0; k < PRF_BANK_COUNT; k++) begin
            if (ext_write[k].valid) begin
                regs[k][ext_write[k].pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]] <= ext_write[k].data;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the ALU lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module alu_reg_core_tb \
    -f tb.f -o alu_reg_core_sim

./obj_dir/alu_reg_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" sim.log

// File: tb.f
core_types_pkg.sv
alu.sv
alu_reg_pipeline.sv
prf.sv
alu_reg_core.sv
alu_reg_core_tb.sv
